//--- logic/cnn_pkg.sv
package cnn_pkg;

	// image, kernel and valid output dimensions
	localparam int IMG_DIM = 8;
	localparam int KER_DIM = 3;
	localparam int OUT_DIM = 6;

	// region codes, taken from address bits 15:12
	localparam logic [3:0] REG_PIXEL  = 4'd0;
	localparam logic [3:0] REG_WEIGHT = 4'd1;
	localparam logic [3:0] REG_BIAS   = 4'd2;
	localparam logic [3:0] REG_START  = 4'd3;
	localparam logic [3:0] REG_IRQ    = 4'd4;
	localparam logic [3:0] REG_RESULT = 4'd5;

	// unsigned image sample
	typedef logic [7:0] pixel_t;

	// signed kernel coefficient and bias
	typedef logic signed [7:0] weight_t;
	typedef logic signed [15:0] bias_t;

	// accumulator, wide enough for 9 * 255 * 127 plus the bias
	typedef logic signed [19:0] acc_t;

	// pixel index is row * IMG_DIM + col
	typedef logic [5:0] pix_addr_t;

	// kernel tap index, 0 to 8
	typedef logic [3:0] wgt_addr_t;

	// result index is out_row * OUT_DIM + out_col
	typedef logic [5:0] res_addr_t;

endpackage

//--- logic/bus_decoder.sv
`timescale 1ns/10ps
module bus_decoder (
	input  logic               clk,
	input  logic               arst_n,
	input  logic [31:0]        araddr,
	input  logic               arvalid,
	input  logic [31:0]        awaddr,
	input  logic               awvalid,
	input  logic [31:0]        wdata,
	input  logic               wvalid,
	input  logic               busy,
	input  logic               done,
	input  cnn_pkg::acc_t      res_rdata,
	output logic               pix_we,
	output cnn_pkg::pix_addr_t pix_waddr,
	output cnn_pkg::pixel_t    pix_wdata,
	output logic               wgt_we,
	output cnn_pkg::wgt_addr_t wgt_waddr,
	output cnn_pkg::weight_t   wgt_wdata,
	output logic               bias_we,
	output cnn_pkg::bias_t     bias_wdata,
	output logic               start,
	output logic               res_re,
	output cnn_pkg::res_addr_t res_raddr,
	output logic [31:0]        rdata,
	output logic               interrupt_signal
);
	logic       wr;
	logic [3:0] wr_region;
	logic       rd_pend;
	logic [3:0] rd_region;

	always_comb
	begin
		wr = awvalid && wvalid;
		wr_region = awaddr[15:12];
		// memory and start writes are locked out while the engine runs
		pix_we  = wr && !busy && (wr_region == cnn_pkg::REG_PIXEL);
		wgt_we  = wr && !busy && (wr_region == cnn_pkg::REG_WEIGHT);
		bias_we = wr && !busy && (wr_region == cnn_pkg::REG_BIAS);
		start   = wr && !busy && (wr_region == cnn_pkg::REG_START) && wdata[0];
		pix_waddr  = awaddr[5:0];
		pix_wdata  = wdata[7:0];
		wgt_waddr  = awaddr[3:0];
		wgt_wdata  = wdata[7:0];
		bias_wdata = wdata[15:0];
		// result memory read goes out with the strobe itself
		res_re    = arvalid && (araddr[15:12] == cnn_pkg::REG_RESULT);
		res_raddr = araddr[5:0];
	end

	// interrupt flag, a set in the same cycle beats the clear
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			interrupt_signal <= 1'b0;
		else if (done)
			interrupt_signal <= 1'b1;
		else if (wr && (wr_region == cnn_pkg::REG_IRQ))
			interrupt_signal <= 1'b0;
	end

	// read path, rdata follows the strobe by one cycle and then holds
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rd_pend   <= 1'b0;
			rd_region <= 4'd0;
			rdata     <= 32'd0;
		end
		else
		begin
			rd_pend <= arvalid;
			if (arvalid)
				rd_region <= araddr[15:12];
			if (rd_pend)
			begin
				case (rd_region)
					cnn_pkg::REG_RESULT: rdata <= {12'd0, res_rdata};
					cnn_pkg::REG_IRQ:    rdata <= {31'd0, interrupt_signal};
					default:             rdata <= 32'd0;
				endcase
			end
		end
	end

endmodule

//--- logic/local_mem_pixel.sv
`timescale 1ns/10ps
module local_mem_pixel (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               pix_we,
	input  cnn_pkg::pix_addr_t pix_waddr,
	input  cnn_pkg::pixel_t    pix_wdata,
	input  cnn_pkg::pix_addr_t pix_raddr,
	output cnn_pkg::pixel_t    pix_rdata
);
	// full 8x8 image, one byte per entry
	cnn_pkg::pixel_t mem [cnn_pkg::IMG_DIM*cnn_pkg::IMG_DIM];

	always_ff @(posedge clk)
	begin
		if (pix_we)
			mem[pix_waddr] <= pix_wdata;
	end

	// registered read, data one cycle after the address
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			pix_rdata <= '0;
		else
			pix_rdata <= mem[pix_raddr];
	end

endmodule

//--- logic/local_mem_weight.sv
`timescale 1ns/10ps
module local_mem_weight (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               wgt_we,
	input  cnn_pkg::wgt_addr_t wgt_waddr,
	input  cnn_pkg::weight_t   wgt_wdata,
	input  logic               bias_we,
	input  cnn_pkg::bias_t     bias_wdata,
	input  cnn_pkg::wgt_addr_t wgt_raddr,
	output cnn_pkg::weight_t   wgt_rdata,
	output cnn_pkg::bias_t     bias_val
);
	cnn_pkg::weight_t mem [cnn_pkg::KER_DIM*cnn_pkg::KER_DIM];

	// tap indices above 8 fall outside the kernel
	always_ff @(posedge clk)
	begin
		if (wgt_we && (wgt_waddr < cnn_pkg::wgt_addr_t'(cnn_pkg::KER_DIM*cnn_pkg::KER_DIM)))
			mem[wgt_waddr] <= wgt_wdata;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wgt_rdata <= '0;
			bias_val  <= '0;
		end
		else
		begin
			wgt_rdata <= mem[wgt_raddr];
			if (bias_we)
				bias_val <= bias_wdata;
		end
	end

endmodule

//--- logic/conv_layer.sv
`timescale 1ns/10ps
module conv_layer (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               start,
	output cnn_pkg::pix_addr_t pix_raddr,
	input  cnn_pkg::pixel_t    pix_rdata,
	output cnn_pkg::wgt_addr_t wgt_raddr,
	input  cnn_pkg::weight_t   wgt_rdata,
	input  cnn_pkg::bias_t     bias_val,
	output logic               res_we,
	output cnn_pkg::res_addr_t res_waddr,
	output cnn_pkg::acc_t      res_wdata,
	output logic               busy,
	output logic               done
);
	typedef enum logic [1:0] {IDLE, MAC, WRITE} state_t;

	state_t             state;
	logic [2:0]         out_row;
	logic [2:0]         out_col;
	logic [1:0]         tap_r;
	logic [1:0]         tap_c;
	cnn_pkg::wgt_addr_t tap;
	cnn_pkg::res_addr_t res_idx;
	cnn_pkg::acc_t      acc;
	logic               tap_vld;
	logic [2:0]         img_row;
	logic [2:0]         img_col;
	logic signed [16:0] product;
	cnn_pkg::acc_t      bias_ext;
	cnn_pkg::acc_t      sum;
	logic               last_tap;
	logic               last_out;

	always_comb
	begin
		// pixel under the current tap
		img_row   = out_row + {1'b0, tap_r};
		img_col   = out_col + {1'b0, tap_c};
		pix_raddr = cnn_pkg::pix_addr_t'(img_row * cnn_pkg::IMG_DIM + img_col);
		wgt_raddr = tap;
		// pixel is unsigned, so a zero bit goes on top before the signed multiply
		product  = $signed({1'b0, pix_rdata}) * wgt_rdata;
		sum      = acc + {{3{product[16]}}, product};
		bias_ext = {{4{bias_val[15]}}, bias_val};
		last_tap = (tap == cnn_pkg::wgt_addr_t'(cnn_pkg::KER_DIM*cnn_pkg::KER_DIM - 1));
		last_out = (res_idx == cnn_pkg::res_addr_t'(cnn_pkg::OUT_DIM*cnn_pkg::OUT_DIM - 1));
		busy      = (state != IDLE);
		// in WRITE the sum already holds the last tap
		res_we    = (state == WRITE);
		res_waddr = res_idx;
		res_wdata = sum[19] ? '0 : sum;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state   <= IDLE;
			out_row <= 3'd0;
			out_col <= 3'd0;
			tap_r   <= 2'd0;
			tap_c   <= 2'd0;
			tap     <= '0;
			res_idx <= '0;
			acc     <= '0;
			tap_vld <= 1'b0;
			done    <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			// read data lands one cycle after each MAC address
			tap_vld <= (state == MAC);
			case (state)
				IDLE:
				begin
					if (start)
					begin
						state   <= MAC;
						out_row <= 3'd0;
						out_col <= 3'd0;
						tap_r   <= 2'd0;
						tap_c   <= 2'd0;
						tap     <= '0;
						res_idx <= '0;
						acc     <= bias_ext;
					end
				end
				MAC:
				begin
					if (tap_vld)
						acc <= sum;
					if (last_tap)
					begin
						state <= WRITE;
						tap   <= '0;
						tap_r <= 2'd0;
						tap_c <= 2'd0;
					end
					else
					begin
						tap <= tap + 4'd1;
						if (tap_c == 2'(cnn_pkg::KER_DIM - 1))
						begin
							tap_c <= 2'd0;
							tap_r <= tap_r + 2'd1;
						end
						else
							tap_c <= tap_c + 2'd1;
					end
				end
				WRITE:
				begin
					acc     <= bias_ext;
					res_idx <= res_idx + 6'd1;
					if (last_out)
					begin
						state <= IDLE;
						done  <= 1'b1;
					end
					else
					begin
						state <= MAC;
						if (out_col == 3'(cnn_pkg::OUT_DIM - 1))
						begin
							out_col <= 3'd0;
							out_row <= out_row + 3'd1;
						end
						else
							out_col <= out_col + 3'd1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- logic/result_mem.sv
`timescale 1ns/10ps
module result_mem (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               res_we,
	input  cnn_pkg::res_addr_t res_waddr,
	input  cnn_pkg::acc_t      res_wdata,
	input  logic               res_re,
	input  cnn_pkg::res_addr_t res_raddr,
	output cnn_pkg::acc_t      res_rdata
);
	// one entry per output position of the 6x6 map
	cnn_pkg::acc_t mem [cnn_pkg::OUT_DIM*cnn_pkg::OUT_DIM];

	always_ff @(posedge clk)
	begin
		if (res_we)
			mem[res_waddr] <= res_wdata;
	end

	// cpu side, indices past the last output read back as zero
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			res_rdata <= '0;
		else if (res_re)
		begin
			if (res_raddr < cnn_pkg::res_addr_t'(cnn_pkg::OUT_DIM*cnn_pkg::OUT_DIM))
				res_rdata <= mem[res_raddr];
			else
				res_rdata <= '0;
		end
	end

endmodule

//--- logic/top.sv
`timescale 1ns/10ps
module top (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [31:0] araddr,
	input  logic        arvalid,
	input  logic [31:0] awaddr,
	input  logic        awvalid,
	input  logic [31:0] wdata,
	input  logic        wvalid,
	output logic [31:0] rdata,
	output logic        interrupt_signal
);
	// cpu write side
	logic               pix_we;
	cnn_pkg::pix_addr_t pix_waddr;
	cnn_pkg::pixel_t    pix_wdata;
	logic               wgt_we;
	cnn_pkg::wgt_addr_t wgt_waddr;
	cnn_pkg::weight_t   wgt_wdata;
	logic               bias_we;
	cnn_pkg::bias_t     bias_wdata;
	logic               start;

	// engine side
	cnn_pkg::pix_addr_t pix_raddr;
	cnn_pkg::pixel_t    pix_rdata;
	cnn_pkg::wgt_addr_t wgt_raddr;
	cnn_pkg::weight_t   wgt_rdata;
	cnn_pkg::bias_t     bias_val;
	logic               res_we;
	cnn_pkg::res_addr_t res_waddr;
	cnn_pkg::acc_t      res_wdata;
	logic               busy;
	logic               done;

	// cpu read of results
	logic               res_re;
	cnn_pkg::res_addr_t res_raddr;
	cnn_pkg::acc_t      res_rdata;

	// port names match the wires one to one
	bus_decoder decode (.*);

	local_mem_pixel pixel_st_mem (.*);

	local_mem_weight weight_st_mem (.*);

	conv_layer execute (.*);

	result_mem result (.*);

endmodule

//--- test/top_tb.sv
`timescale 1ns/10ps
module top_tb;
	logic        clk;
	logic        arst_n;
	logic [31:0] araddr;
	logic        arvalid;
	logic [31:0] awaddr;
	logic        awvalid;
	logic [31:0] wdata;
	logic        wvalid;
	logic [31:0] rdata;
	logic        interrupt_signal;

	// image as the testbench wrote it, kernel and model outputs of the current case
	cnn_pkg::pixel_t pix [64];
	int              weights [9];
	int              expected [36];

	top DUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// region in bits 15:12, index in the low bits
	function automatic logic [31:0] reg_addr(input logic [3:0] region, input int index);
		return {16'd0, region, 6'd0, 6'(index)};
	endfunction

	task automatic check_value(input string name, input int exp_val, input int act_val);
		assert (act_val == exp_val)
		else
		begin
			$display("Fail at %0d ns: %s expected %0d, got %0d", $time, name, exp_val, act_val);
			$display("Done: errors found");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk);
		awaddr  <= addr;
		wdata   <= data;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
	endtask

	task automatic bus_read(input logic [31:0] addr, output int data);
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		@(posedge clk);
		arvalid <= 1'b0;
		// rdata loads on the edge after the strobe is taken
		@(posedge clk);
		@(negedge clk);
		data = int'(rdata);
	endtask

	task automatic wait_irq();
		int cycles;
		cycles = 0;
		while (!interrupt_signal && cycles < 1000)
		begin
			@(negedge clk);
			cycles++;
		end
		assert (interrupt_signal)
		else
		begin
			$display("Timeout at %0d ns: the interrupt never came after the start write", $time);
			$display("Done: errors found");
			$fatal(1, "interrupt timeout");
		end
	endtask

	task automatic load_image(input logic [31:0] seed);
		logic [31:0] state;
		state = 32'h6a88 ^ seed;
		for (int i = 0; i < 64; i++)
		begin
			state = lcg_next(state);
			pix[i] = state[7:0];
			bus_write(reg_addr(cnn_pkg::REG_PIXEL, i), {24'd0, pix[i]});
		end
	endtask

	// valid 3x3 convolution with ReLU
	task automatic compute_model(input int bias);
		int acc;
		for (int r = 0; r < 6; r++)
		begin
			for (int c = 0; c < 6; c++)
			begin
				acc = bias;
				for (int t = 0; t < 9; t++)
					acc += int'(pix[(r + t / 3) * 8 + c + t % 3]) * weights[t];
				expected[r * 6 + c] = (acc < 0) ? 0 : acc;
			end
		end
	endtask

	task automatic run_case(input logic [31:0] seed, input int bias, input int file_sum);
		int value;
		int total;
		// seed 0 keeps the image from the last case
		if (seed != 0)
			load_image(seed);
		for (int t = 0; t < 9; t++)
			bus_write(reg_addr(cnn_pkg::REG_WEIGHT, t), 32'(weights[t]));
		bus_write(reg_addr(cnn_pkg::REG_BIAS, 0), 32'(bias));
		compute_model(bias);
		bus_write(reg_addr(cnn_pkg::REG_START, 0), 32'd1);
		// pixel 63 is only read by the last output, long after this write must be dropped
		bus_write(reg_addr(cnn_pkg::REG_PIXEL, 63), {24'd0, ~pix[63]});
		wait_irq();
		bus_read(reg_addr(cnn_pkg::REG_IRQ, 0), value);
		check_value("rdata irq pending", 1, value);
		bus_write(reg_addr(cnn_pkg::REG_IRQ, 0), 32'd1);
		@(negedge clk);
		check_value("interrupt_signal", 0, int'(interrupt_signal));
		bus_read(reg_addr(cnn_pkg::REG_IRQ, 0), value);
		check_value("rdata irq cleared", 0, value);
		total = 0;
		for (int i = 0; i < 36; i++)
		begin
			bus_read(reg_addr(cnn_pkg::REG_RESULT, i), value);
			check_value($sformatf("rdata result[%0d]", i), expected[i], value);
			total += value;
		end
		check_value("sum of results", file_sum, total);
	endtask

	initial
	begin
		int          fd;
		int          count;
		int          cases;
		int          bias;
		int          file_sum;
		int          value;
		string       line;
		logic [31:0] seed;
		cases  = 0;
		arst_n  <= 1'b0;
		araddr  <= '0;
		arvalid <= 1'b0;
		awaddr  <= '0;
		awvalid <= 1'b0;
		wdata   <= '0;
		wvalid  <= 1'b0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_value("interrupt_signal after reset", 0, int'(interrupt_signal));
		bus_read(reg_addr(cnn_pkg::REG_IRQ, 0), value);
		check_value("rdata irq after reset", 0, value);
		bus_read(reg_addr(cnn_pkg::REG_RESULT, 40), value);
		check_value("rdata result after reset", 0, value);

		fd = $fopen("test/cnn_cases.txt", "r");
		assert (fd != 0)
		else
		begin
			$display("Could not open the case file test/cnn_cases.txt");
			$display("Done: errors found");
			$fatal(1, "missing case file");
		end
		while (!$feof(fd))
		begin
			line = "";
			count = $fgets(line, fd);
			if (line.len() > 1 && line[0] != "#")
			begin
				count = $sscanf(line, "%h %d %d %d %d %d %d %d %d %d %d %d", seed,
					weights[0], weights[1], weights[2], weights[3], weights[4],
					weights[5], weights[6], weights[7], weights[8], bias, file_sum);
				assert (count == 12)
				else
				begin
					$display("A line of the case file has the wrong number of fields");
					$display("Done: errors found");
					$fatal(1, "bad case line");
				end
				run_case(seed, bias, file_sum);
				cases++;
			end
		end
		$fclose(fd);

		if (cases > 0)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
		begin
			$display("No case was run from the case file");
			$display("Done: errors found");
			$fatal(1, "no cases");
		end
	end

endmodule

//--- test/cnn_cases.txt
# seed(hex) w0 w1 w2 w3 w4 w5 w6 w7 w8 bias expected_sum
# taps in row order, seed 0 keeps the image already in the pixel memory
2f -5 -3 -1 -7 2 -4 -2 -6 -1 -1200 0
88 1 2 1 2 4 2 1 2 1 50 70056
0 0 -1 0 -1 5 -1 0 -1 0 1100 44206
0 3 0 -2 0 0 0 -2 0 3 1100 47996
0 127 127 127 127 127 127 127 127 127 32767 6029742
88 0 0 0 0 1 0 0 0 0 0 4334
5c 0 0 0 0 0 0 0 0 0 300 10800

//--- top.f
logic/cnn_pkg.sv
logic/bus_decoder.sv
logic/local_mem_pixel.sv
logic/local_mem_weight.sv
logic/conv_layer.sv
logic/result_mem.sv
logic/top.sv
test/top_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f top.f --top-module top_tb -o top_tb_sim \
	&& ./obj_dir/top_tb_sim | tee sim.log
grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
